//--- vlog.f
ac_pkg.sv
tdoa_ifs.sv
mic_ws_timer.sv
mic_capture_buf.sv
xcorr_engine.sv
tdoa_ctrl.sv
tdoa_apb_regs.sv
tdoa_top.sv
tdoa_checker.sv
tb_tdoa.sv

//--- Makefile
# Verilator build and run of the TDOA testbench

VERILATOR ?= verilator
TOP       ?= tb_tdoa
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_tdoa.sv
`default_nettype none

module tb_tdoa;

timeunit 1ns;
timeprecision 100ps;

localparam int CLK_PERIOD   = 4;
localparam int RST_CYCLES   = 16;
localparam int NTEST        = 5;
localparam int CYC_PER_TEST = 8000;       // capture plus six sweeps take about 7100
localparam int WD_CYCLES    = NTEST * CYC_PER_TEST + 4000;   // margin for register tests
localparam int BASE_LEN     = 71;         // 64 samples plus the largest delay
localparam int K_RAND       = 0;
localparam int K_ONES       = 1;
localparam int K_ALT        = 2;

//////////////////////////////
// test table
//////////////////////////////
string t_name [NTEST] = '{"rand_spread", "rand_reverse", "rand_restart",
                          "all_ones", "alternating"};
int    t_kind [NTEST] = '{K_RAND, K_RAND, K_RAND, K_ONES, K_ALT};
int    t_dly  [NTEST][4] = '{'{0, 3, 5, 7}, '{7, 2, 4, 0}, '{2, 2, 6, 1},
                            '{0, 3, 5, 7}, '{0, 1, 4, 6}};   // per mic delay
logic  t_irq  [NTEST] = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1};   // irq_en
logic  t_rest [NTEST] = '{1'b0, 1'b1, 1'b1, 1'b0, 1'b0};   // second start while busy

logic                       clk;
logic                       arst_n;
logic                       psel;
logic                       penable;
logic                       pwrite;
logic [7:0]                 paddr;
logic [31:0]                pwdata;
logic [ac_pkg::MIC_NUM-1:0] mic_data;
wire  [31:0]                prdata;
wire                        pready;
wire                        pslverr;
wire                        mic_ws;
wire                        irq;

logic base [BASE_LEN];
int   dly [4];
int   s_idx;
logic feeding;
logic ws_last;

tdoa_top tdoa_top_i (
     .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite)
    ,.paddr(paddr), .pwdata(pwdata), .mic_data(mic_data), .prdata(prdata)
    ,.pready(pready), .pslverr(pslverr), .mic_ws(mic_ws), .irq(irq)
);

tdoa_checker mon (
     .clk(clk), .arst_n(arst_n), .psel(psel), .penable(penable), .pwrite(pwrite)
    ,.paddr(paddr), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    ,.mic_ws(mic_ws), .irq(irq)
);

always #(CLK_PERIOD / 2) clk = ~clk;

//////////////////////////////
// mic streams
//////////////////////////////
function automatic logic [3:0] mic_word(int s);
    logic [3:0] w;
    for (int k = 0; k < 4; k++)
        w[k] = base[s + 7 - dly[k]];       // later mic sees older base sample
    return w;
endfunction

// next sample goes out once ws has dropped
always @(negedge clk) begin
    if (feeding && ws_last && !mic_ws && s_idx < ac_pkg::WIN_LEN - 1) begin
        s_idx    = s_idx + 1;
        mic_data = mic_word(s_idx);
        mon.push_sample(mic_data);
    end
    ws_last = mic_ws;
end

task automatic build_base(int kind);
    for (int i = 0; i < BASE_LEN; i++) begin
        case (kind)
            K_RAND:  base[i] = 1'($urandom);
            K_ONES:  base[i] = 1'b1;
            default: base[i] = 1'(i);      // 0101...
        endcase
    end
endtask

//////////////////////////////
// apb master
//////////////////////////////
task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;                        // setup phase
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;                        // access phase completes on next rise
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    #1;
    data    = prdata;                      // settled by mid low phase
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
endtask

//////////////////////////////
// test sequences
//////////////////////////////
task automatic check_reset();
    logic [31:0] d;
    mon.begin_test("reset_values");
    mon.expect_irq("irq after reset", 1'b0);
    mon.expect_ws_low("mic_ws after reset");
    apb_read(ac_pkg::ADDR_CTRL, d);
    mon.expect_rd("ctrl", 32'h0);
    apb_read(ac_pkg::ADDR_STATUS, d);
    mon.expect_rd("status", 32'h0);
    for (int p = 0; p < ac_pkg::PAIR_NUM; p++) begin
        apb_read(ac_pkg::ADDR_LAG0 + 8'(4 * p), d);
        mon.expect_rd($sformatf("lag%0d", p), 32'h0);
    end
    mon.end_test();
endtask

task automatic run_measure(int t);
    logic [31:0] st;
    logic [31:0] ctrl_wd;
    ctrl_wd = {30'b0, t_irq[t], 1'b1};     // start plus irq_en
    mon.begin_test(t_name[t]);
    for (int k = 0; k < 4; k++)
        dly[k] = t_dly[t][k];
    build_base(t_kind[t]);
    @(negedge clk);
    s_idx    = 0;
    mic_data = mic_word(0);                // held until the first tick
    mon.push_sample(mic_data);
    feeding  = 1'b1;
    mon.ws_start();
    apb_write(ac_pkg::ADDR_CTRL, ctrl_wd);
    if (t_rest[t]) begin
        apb_write(ac_pkg::ADDR_CTRL, ctrl_wd);
        apb_read(ac_pkg::ADDR_STATUS, st);
        mon.expect_rd("status after second start", 32'h1);
    end
    // poll until the sticky done bit is set
    st = '0;
    while (!st[ac_pkg::STAT_DONE_BIT])
        apb_read(ac_pkg::ADDR_STATUS, st);
    mon.expect_rd("status at done", 32'h2);
    mon.expect_irq("irq at done", t_irq[t]);
    mon.ws_stop();
    feeding = 1'b0;
    apb_write(ac_pkg::ADDR_STATUS, 32'h2); // clear sticky done
    apb_read(ac_pkg::ADDR_STATUS, st);
    mon.expect_rd("status after clear", 32'h0);
    mon.expect_irq("irq after clear", 1'b0);
    for (int p = 0; p < ac_pkg::PAIR_NUM; p++)
        apb_read(ac_pkg::ADDR_LAG0 + 8'(4 * p), st);
    mon.end_test();
endtask

task automatic check_bad_access();
    logic [31:0] d;
    mon.begin_test("bad_access");
    apb_read(8'h20, d);                    // just past lag5
    mon.expect_err("unmapped read pslverr", 1'b1);
    mon.expect_rd("unmapped read data", 32'h0);
    apb_write(ac_pkg::ADDR_LAG0, 32'h15);
    mon.expect_err("lag write pslverr", 1'b1);
    apb_read(ac_pkg::ADDR_LAG0, d);
    mon.expect_err("lag read pslverr", 1'b0);
    mon.expect_lag("lag0 after write", 0);
    apb_write(8'h40, 32'h1);               // would start and clear irq_en if decoded
    mon.expect_err("unmapped write pslverr", 1'b1);
    apb_read(ac_pkg::ADDR_CTRL, d);
    mon.expect_rd("ctrl unchanged", {30'b0, t_irq[NTEST-1], 1'b0});
    apb_read(ac_pkg::ADDR_STATUS, d);
    mon.expect_rd("status unchanged", 32'h0);
    mon.expect_ws_low("mic_ws when idle");
    mon.end_test();
endtask

//////////////////////////////
// main and watchdog
//////////////////////////////
initial begin
    clk      = 1'b0;
    arst_n   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    mic_data = '0;
    feeding  = 1'b0;
    ws_last  = 1'b0;
    s_idx    = 0;
    void'($urandom(3));                    // one seed for the whole run
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    check_reset();
    for (int t = 0; t < NTEST; t++)
        run_measure(t);
    check_bad_access();
    mon.report();
    if (mon.err_total == 0)
        $display("TEST PASSED");
    else
        $display("TEST FAILED");
    $finish;
end

initial begin
    #(WD_CYCLES * CLK_PERIOD);
    $display("watchdog: run did not finish within %0d cycles", WD_CYCLES);
    $display("TEST FAILED");
    $finish;
end

endmodule

`default_nettype wire

//--- tdoa_checker.sv
`default_nettype none

module tdoa_checker (
     input  wire         clk
    ,input  wire         arst_n
    ,input  wire         psel
    ,input  wire         penable
    ,input  wire         pwrite
    ,input  wire [7:0]   paddr
    ,input  wire [31:0]  prdata
    ,input  wire         pready
    ,input  wire         pslverr
    ,input  wire         mic_ws
    ,input  wire         irq
);

timeunit 1ns;
timeprecision 100ps;

localparam logic [31:0] NO_READ = 32'h0bad_0bad;   // lag register not read in this test

string       cur_name = "none";
logic [3:0]  smp [$];                  // driven samples, bit k is mic k
logic [31:0] lag_rd  [ac_pkg::PAIR_NUM];
int          exp_lag [ac_pkg::PAIR_NUM];  // kept across tests
logic [31:0] last_rdata = '0;
logic        last_err = 1'b0;
logic        ws_prev = 1'b0;
logic        ws_open = 1'b0;           // capture expected
int          ws_rises = 0;
int          test_err = 0;
int          err_total = 0;
int          n_tests = 0;
int          n_bad = 0;

//////////////////////////////
// bus and pin watchers
//////////////////////////////
always @(posedge clk) begin
    if (arst_n && psel && penable) begin   // access phase, transfer completes here
        last_err = pslverr;
        if (!pready) begin
            $display("%s: pready was low in an access phase", cur_name);
            note_fail();
        end
        if (!pwrite) begin
            last_rdata = prdata;
            if (paddr >= ac_pkg::ADDR_LAG0 && paddr <= 8'h1c && paddr[1:0] == 2'b00)
                lag_rd[int'((paddr - ac_pkg::ADDR_LAG0) >> 2)] = prdata;
        end
    end
end

// mic_ws settles after the rising edge
always @(negedge clk) begin
    if (arst_n && mic_ws && !ws_prev) begin
        if (ws_open)
            ws_rises++;
        else begin
            $display("%s: mic_ws rose while the design was idle", cur_name);
            note_fail();
        end
    end
    ws_prev = mic_ws;
end

task automatic note_fail();
    test_err++;
    err_total++;
endtask

task automatic mismatch(string what, int exp, int act);
    $display("ERR %s: %s expected %0d actual %0d", cur_name, what, exp, act);
    note_fail();
endtask

//////////////////////////////
// expected lags, brute force
//////////////////////////////
function automatic int best_lag(int p);
    int best_sc;
    int best_l;
    int sc;
    best_sc = -1;
    best_l  = 0;
    for (int l = -ac_pkg::LAG_MAX; l <= ac_pkg::LAG_MAX; l++) begin
        sc = 0;
        for (int n = ac_pkg::N_LO; n <= ac_pkg::N_HI; n++)
            if (smp[n][ac_pkg::PAIR_A[p]] == smp[n + l][ac_pkg::PAIR_B[p]])
                sc++;                      // agreement count
        if (sc > best_sc) begin            // strict, so a tie keeps the lower lag
            best_sc = sc;
            best_l  = l;
        end
    end
    return best_l;
endfunction

//////////////////////////////
// tasks called by the testbench
//////////////////////////////
task automatic begin_test(string name);
    cur_name = name;
    test_err = 0;
    smp.delete();
    foreach (lag_rd[p])
        lag_rd[p] = NO_READ;
endtask

task automatic push_sample(logic [3:0] s);
    smp.push_back(s);
endtask

task automatic expect_rd(string what, logic [31:0] exp);
    if (last_rdata !== exp)
        mismatch(what, $signed(exp), $signed(last_rdata));
endtask

task automatic expect_err(string what, logic exp);
    if (last_err !== exp)
        mismatch(what, int'(exp), int'(last_err));
endtask

task automatic expect_irq(string what, logic exp);
    if (irq !== exp)
        mismatch(what, int'(exp), int'(irq));
endtask

task automatic expect_ws_low(string what);
    if (mic_ws !== 1'b0)
        mismatch(what, 0, int'(mic_ws));
endtask

task automatic expect_lag(string what, int p);
    logic [31:0] e;
    e = exp_lag[p];                        // sign-extended lag
    if (last_rdata !== e)
        mismatch(what, exp_lag[p], $signed(last_rdata));
endtask

task automatic ws_start();
    ws_rises = 0;
    ws_open  = 1'b1;
endtask

task automatic ws_stop();
    ws_open = 1'b0;
    if (ws_rises != ac_pkg::WIN_LEN)
        mismatch("mic_ws rises per window", ac_pkg::WIN_LEN, ws_rises);
endtask

task automatic end_test();
    logic [31:0] e;
    if (smp.size() == ac_pkg::WIN_LEN + 0) begin
        for (int p = 0; p < ac_pkg::PAIR_NUM; p++) begin
            exp_lag[p] = best_lag(p);
            e = exp_lag[p];
            if (lag_rd[p] !== e)
                mismatch($sformatf("lag%0d", p), exp_lag[p], $signed(lag_rd[p]));
        end
    end else if (smp.size() != 0) begin
        $display("%s: only %0d samples were driven", cur_name, smp.size());
        note_fail();
    end
    n_tests++;
    if (test_err != 0)
        n_bad++;
    if (test_err == 0)
        $display("test %s: ok", cur_name);
    else
        $display("test %s: %0d errors", cur_name, test_err);
endtask

task automatic report();
    $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_bad, err_total);
endtask

endmodule

`default_nettype wire

//--- tdoa_top.sv
`default_nettype none

module tdoa_top (
     input  wire                        clk
    ,input  wire                        arst_n
    ,input  wire                        psel
    ,input  wire                        penable
    ,input  wire                        pwrite
    ,input  wire [7:0]                  paddr
    ,input  wire [31:0]                 pwdata
    ,input  wire [ac_pkg::MIC_NUM-1:0]  mic_data
    ,output wire [31:0]                 prdata
    ,output wire                        pready
    ,output wire                        pslverr
    ,output wire                        mic_ws
    ,output wire                        irq
);

logic               cap_en;
logic               sample_tick;
logic               win_full;
ac_pkg::sidx_t      sample_idx;
logic               start_req;
logic               busy;
logic               meas_done;
logic               lag_wr_en;
ac_pkg::pair_idx_t  lag_wr_idx;
ac_pkg::lag_t       lag_wr_data;

hist_rd_if  hist_rd ();      // engine reads buffer
corr_ctl_if corr_ctl ();     // ctrl drives engine

//////////////////////////////
// capture path
//////////////////////////////
mic_ws_timer mic_ws_timer_i (
     .clk           (clk            ) //i
    ,.arst_n        (arst_n         ) //i
    ,.cap_en        (cap_en         ) //i
    ,.mic_ws        (mic_ws         ) //o
    ,.sample_tick   (sample_tick    ) //o
    ,.win_full      (win_full       ) //o
    ,.sample_idx    (sample_idx     ) //o
);

mic_capture_buf mic_capture_buf_i (
     .clk           (clk            ) //i
    ,.arst_n        (arst_n         ) //i
    ,.sample_tick   (sample_tick    ) //i
    ,.sample_idx    (sample_idx     ) //i
    ,.mic_data      (mic_data       ) //i [4-1:0]
    ,.rd            (hist_rd.buffer )
);

//////////////////////////////
// correlation and control
//////////////////////////////
xcorr_engine xcorr_engine_i (
     .clk           (clk            ) //i
    ,.arst_n        (arst_n         ) //i
    ,.ctl           (corr_ctl.engine)
    ,.rd            (hist_rd.engine )
);

tdoa_ctrl tdoa_ctrl_i (
     .clk           (clk            ) //i
    ,.arst_n        (arst_n         ) //i
    ,.start_req     (start_req      ) //i
    ,.win_full      (win_full       ) //i
    ,.cap_en        (cap_en         ) //o
    ,.busy          (busy           ) //o
    ,.meas_done     (meas_done      ) //o
    ,.lag_wr_en     (lag_wr_en      ) //o
    ,.lag_wr_idx    (lag_wr_idx     ) //o
    ,.lag_wr_data   (lag_wr_data    ) //o signed [6-1:0]
    ,.ctl           (corr_ctl.ctrl  )
);

tdoa_apb_regs tdoa_apb_regs_i (
     .clk           (clk            ) //i
    ,.arst_n        (arst_n         ) //i
    ,.psel          (psel           ) //i
    ,.penable       (penable        ) //i
    ,.pwrite        (pwrite         ) //i
    ,.paddr         (paddr          ) //i [8-1:0]
    ,.pwdata        (pwdata         ) //i [32-1:0]
    ,.busy          (busy           ) //i
    ,.meas_done     (meas_done      ) //i
    ,.lag_wr_en     (lag_wr_en      ) //i
    ,.lag_wr_idx    (lag_wr_idx     ) //i
    ,.lag_wr_data   (lag_wr_data    ) //i
    ,.prdata        (prdata         ) //o [32-1:0]
    ,.pready        (pready         ) //o
    ,.pslverr       (pslverr        ) //o
    ,.start_req     (start_req      ) //o
    ,.irq           (irq            ) //o
);

endmodule

`default_nettype wire

//--- tdoa_apb_regs.sv
`default_nettype none

module tdoa_apb_regs (
     input  wire                        clk
    ,input  wire                        arst_n
    ,input  wire                        psel
    ,input  wire                        penable
    ,input  wire                        pwrite
    ,input  wire [7:0]                  paddr
    ,input  wire [31:0]                 pwdata
    ,input  wire                        busy
    ,input  wire                        meas_done
    ,input  wire                        lag_wr_en
    ,input  wire ac_pkg::pair_idx_t     lag_wr_idx
    ,input  wire ac_pkg::lag_t          lag_wr_data
    ,output logic [31:0]                prdata
    ,output logic                       pready
    ,output logic                       pslverr
    ,output logic                       start_req
    ,output logic                       irq
);

logic               irq_en;
logic               done_q;                     // sticky done
ac_pkg::lag_t       lag_q [ac_pkg::PAIR_NUM];
logic               access;
logic               wr_acc;
logic               hit_ctrl;
logic               hit_status;
logic               hit_lag;
logic [7:0]         lag_off;
ac_pkg::pair_idx_t  lag_idx;

//////////////////////////////
// address decode
//////////////////////////////
assign access     = psel && penable;        // zero wait so the access phase completes
assign wr_acc     = access && pwrite && !pslverr;
assign lag_off    = paddr - ac_pkg::ADDR_LAG0;
assign lag_idx    = lag_off[4:2];
assign hit_ctrl   = (paddr == ac_pkg::ADDR_CTRL);
assign hit_status = (paddr == ac_pkg::ADDR_STATUS);
assign hit_lag    = (paddr >= ac_pkg::ADDR_LAG0) && (lag_off[1:0] == 2'b00)
                    && (lag_off[7:2] < ac_pkg::PAIR_NUM);

assign pready  = 1'b1;
assign pslverr = access && (!(hit_ctrl || hit_status || hit_lag) || (pwrite && hit_lag));
assign irq     = done_q && irq_en;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        irq_en    <= 1'b0;
        done_q    <= 1'b0;
        start_req <= 1'b0;
        for (int i = 0; i < ac_pkg::PAIR_NUM; i++)
            lag_q[i] <= '0;
    end else begin
        // start dropped while a measurement runs
        start_req <= wr_acc && hit_ctrl && pwdata[ac_pkg::CTRL_START_BIT] && !busy;
        if (wr_acc && hit_ctrl)
            irq_en <= pwdata[ac_pkg::CTRL_IRQ_EN_BIT];
        if (meas_done)
            done_q <= 1'b1;                 // set beats clear
        else if (wr_acc && hit_status && pwdata[ac_pkg::STAT_DONE_BIT])
            done_q <= 1'b0;
        if (lag_wr_en)
            lag_q[lag_wr_idx] <= lag_wr_data;
    end
end

//////////////////////////////
// read mux
//////////////////////////////
always_comb begin
    prdata = '0;                            // unmapped reads zero
    if (psel && !pwrite) begin
        if (hit_ctrl)
            prdata[ac_pkg::CTRL_IRQ_EN_BIT] = irq_en;   // start reads back 0
        else if (hit_status) begin
            prdata[ac_pkg::STAT_BUSY_BIT] = busy;
            prdata[ac_pkg::STAT_DONE_BIT] = done_q;
        end else if (hit_lag)
            prdata = 32'(lag_q[lag_idx]);   // sign-extended lag
    end
end

a_apb_enable_in_sel: assert property (@(posedge clk) disable iff (!arst_n)
    penable |-> psel);

endmodule

`default_nettype wire

//--- tdoa_ctrl.sv
`default_nettype none

module tdoa_ctrl (
     input  wire                 clk
    ,input  wire                 arst_n
    ,input  wire                 start_req
    ,input  wire                 win_full
    ,output logic                cap_en
    ,output logic                busy
    ,output logic                meas_done
    ,output logic                lag_wr_en
    ,output ac_pkg::pair_idx_t   lag_wr_idx
    ,output ac_pkg::lag_t        lag_wr_data
    ,corr_ctl_if.ctrl            ctl
);

typedef enum logic [2:0] {
    IDLE,
    CAPTURE,         // one window from the timer
    CORR_START,
    CORR_WAIT,
    FINISH
} ctrl_st_t;

ctrl_st_t           state;
ac_pkg::pair_idx_t  pair;
logic               pair_pend;    // engine holds a pair

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state     <= IDLE;
        pair      <= '0;
        pair_pend <= 1'b0;
    end else begin
        if (ctl.start)
            pair_pend <= 1'b1;
        else if (ctl.done)
            pair_pend <= 1'b0;

        case (state)
            IDLE:       if (start_req) begin
                            pair  <= '0;
                            state <= CAPTURE;
                        end
            CAPTURE:    if (win_full) state <= CORR_START;
            CORR_START: state <= CORR_WAIT;    // start pulse goes out here
            CORR_WAIT:  if (ctl.done) begin
                            if (pair == ac_pkg::pair_idx_t'(ac_pkg::PAIR_NUM - 1))
                                state <= FINISH;
                            else begin
                                pair  <= pair + 1'b1;
                                state <= CORR_START;
                            end
                        end
            FINISH:     state <= IDLE;
            default:    state <= IDLE;
        endcase
    end
end

assign cap_en      = (state == CAPTURE);
assign busy        = (state != IDLE);
assign meas_done   = (state == FINISH);
assign ctl.start   = (state == CORR_START);
assign ctl.pair    = pair;
assign lag_wr_en   = (state == CORR_WAIT) && ctl.done;   // store as each pair lands
assign lag_wr_idx  = pair;
assign lag_wr_data = ctl.best_lag;

a_no_restart: assert property (@(posedge clk) disable iff (!arst_n)
    ctl.start |-> !pair_pend);

// engine answers only a pair it was given
a_done_owned: assert property (@(posedge clk) disable iff (!arst_n)
    ctl.done |-> pair_pend);

endmodule

`default_nettype wire

//--- xcorr_engine.sv
`default_nettype none

module xcorr_engine (
     input  wire            clk
    ,input  wire            arst_n
    ,corr_ctl_if.engine     ctl
    ,hist_rd_if.engine      rd
);

typedef enum logic [1:0] {
    E_IDLE,
    E_ACC,           // one scored index per cycle
    E_CMP            // compare and step lag
} eng_st_t;

eng_st_t          state;
ac_pkg::lag_t     lag;
ac_pkg::sidx_t    n;
ac_pkg::score_t   score;
ac_pkg::score_t   best_score;
ac_pkg::lag_t     best_lag;
logic             done_q;
logic signed [6:0] idx_b_s;  // n + lag before truncation
logic             match;

//////////////////////////////
// history reads
//////////////////////////////
assign rd.mic_a = ac_pkg::PAIR_A[ctl.pair];
assign rd.mic_b = ac_pkg::PAIR_B[ctl.pair];
assign rd.idx_a = n;
assign idx_b_s  = $signed({1'b0, n}) + lag;    // b runs lag samples ahead of a
assign rd.idx_b = idx_b_s[5:0];
assign match    = (rd.bit_a == rd.bit_b);      // agreement, not product

assign ctl.done     = done_q;
assign ctl.best_lag = best_lag;

//////////////////////////////
// lag sweep
//////////////////////////////
always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        state      <= E_IDLE;
        lag        <= '0;
        n          <= '0;
        score      <= '0;
        best_score <= '0;
        best_lag   <= '0;
        done_q     <= 1'b0;
    end else begin
        done_q <= 1'b0;
        case (state)
            E_IDLE: begin
                if (ctl.start) begin
                    lag        <= ac_pkg::lag_t'(-ac_pkg::LAG_MAX);
                    n          <= ac_pkg::sidx_t'(ac_pkg::N_LO);
                    score      <= '0;
                    best_score <= '0;
                    best_lag   <= ac_pkg::lag_t'(-ac_pkg::LAG_MAX); // all-zero scores
                    state      <= E_ACC;
                end
            end
            E_ACC: begin
                score <= score + {5'b0, match};
                if (n == ac_pkg::sidx_t'(ac_pkg::N_HI))
                    state <= E_CMP;        // last term added on this edge
                else
                    n <= n + 1'b1;
            end
            E_CMP: begin
                // strict compare, ties keep the earlier (more negative) lag
                if (score > best_score) begin
                    best_score <= score;
                    best_lag   <= lag;
                end
                if (lag == ac_pkg::lag_t'(ac_pkg::LAG_MAX)) begin
                    done_q <= 1'b1;        // best_lag settles on this edge
                    state  <= E_IDLE;
                end else begin
                    lag   <= lag + 1'b1;
                    n     <= ac_pkg::sidx_t'(ac_pkg::N_LO);
                    score <= '0;
                    state <= E_ACC;
                end
            end
            default: state <= E_IDLE;
        endcase
    end
end

a_lag_in_range: assert property (@(posedge clk) disable iff (!arst_n)
    state != E_IDLE |-> (lag >= -ac_pkg::LAG_MAX) && (lag <= ac_pkg::LAG_MAX));

// score window chosen so no lag reaches past the buffer
a_idx_in_window: assert property (@(posedge clk) disable iff (!arst_n)
    state == E_ACC |-> (idx_b_s >= 0) && (idx_b_s < ac_pkg::WIN_LEN));

endmodule

`default_nettype wire

//--- mic_capture_buf.sv
`default_nettype none

module mic_capture_buf (
     input  wire                          clk
    ,input  wire                          arst_n
    ,input  wire                          sample_tick
    ,input  wire ac_pkg::sidx_t           sample_idx
    ,input  wire [ac_pkg::MIC_NUM-1:0]    mic_data
    ,hist_rd_if.buffer                    rd
);

//////////////////////////////
// sample histories
//////////////////////////////
logic [ac_pkg::WIN_LEN-1:0] hist [ac_pkg::MIC_NUM];   // one bit per sample

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        for (int k = 0; k < ac_pkg::MIC_NUM; k++)
            hist[k] <= '0;
    end else if (sample_tick) begin
        // all mics sampled on the same edge
        for (int k = 0; k < ac_pkg::MIC_NUM; k++)
            hist[k][sample_idx] <= mic_data[k];
    end
end

//////////////////////////////
// dual bit read
//////////////////////////////
// two independent ports, any mic and index
assign rd.bit_a = hist[rd.mic_a][rd.idx_a];
assign rd.bit_b = hist[rd.mic_b][rd.idx_b];   // shifted stream

endmodule

`default_nettype wire

//--- mic_ws_timer.sv
`default_nettype none

module mic_ws_timer (
     input  wire            clk
    ,input  wire            arst_n
    ,input  wire            cap_en
    ,output logic           mic_ws
    ,output logic           sample_tick
    ,output logic           win_full
    ,output ac_pkg::sidx_t  sample_idx
);

ac_pkg::ph_t   ph;
ac_pkg::ph_t   ph_nxt;
ac_pkg::sidx_t cnt;          // ticks taken in this window

// idle phase sits at the start of the low half
// so the first period after enable opens with a low half
assign sample_tick = (ph == ac_pkg::ph_t'(ac_pkg::WS_DIV - 1));   // last low cycle
assign ph_nxt      = sample_tick ? '0 : ph + 1'b1;
assign sample_idx  = cnt;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        ph     <= ac_pkg::ph_t'(ac_pkg::WS_DIV / 2);
        mic_ws <= 1'b0;
    end else if (!cap_en) begin
        ph     <= ac_pkg::ph_t'(ac_pkg::WS_DIV / 2);  // park, ws low
        mic_ws <= 1'b0;
    end else begin
        ph     <= ph_nxt;
        mic_ws <= (ph_nxt < ac_pkg::ph_t'(ac_pkg::WS_DIV / 2)); // rises with the tick edge
    end
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        cnt      <= '0;
        win_full <= 1'b0;
    end else if (!cap_en) begin
        cnt      <= '0;
        win_full <= 1'b0;
    end else begin
        win_full <= sample_tick && (cnt == ac_pkg::sidx_t'(ac_pkg::WIN_LEN - 1));
        if (sample_tick)
            cnt <= cnt + 1'b1;   // wraps to 0 after the 64th
    end
end

// controller must drop cap_en clear of the tick phase
a_tick_needs_cap: assert property (@(posedge clk) disable iff (!arst_n)
    sample_tick |-> cap_en);

endmodule

`default_nettype wire

//--- tdoa_ifs.sv
`default_nettype none

// sample history read port, two bits per cycle
interface hist_rd_if;
    ac_pkg::mic_sel_t mic_a;
    ac_pkg::mic_sel_t mic_b;
    ac_pkg::sidx_t    idx_a;
    ac_pkg::sidx_t    idx_b;
    logic             bit_a;      // same cycle as the address
    logic             bit_b;

    modport engine (output mic_a, mic_b, idx_a, idx_b, input bit_a, bit_b);
    modport buffer (input mic_a, mic_b, idx_a, idx_b, output bit_a, bit_b);
endinterface

// controller to correlator handshake
interface corr_ctl_if;
    logic              start;     // one cycle, engine idle only
    ac_pkg::pair_idx_t pair;      // held until done
    logic              done;      // one cycle
    ac_pkg::lag_t      best_lag;  // valid with done

    modport ctrl   (output start, pair, input done, best_lag);
    modport engine (input start, pair, output done, best_lag);
endinterface

`default_nettype wire

//--- ac_pkg.sv
`default_nettype none

package ac_pkg;

    //////////////////////////////
    // array and window sizes
    //////////////////////////////
    localparam int MIC_NUM  = 4;
    localparam int PAIR_NUM = 6;              // all pairs of 4 mics
    localparam int WIN_LEN  = 64;             // samples per capture window
    localparam int LAG_MAX  = 15;             // search -15 .. +15
    localparam int N_LO     = 15;             // first scored index
    localparam int N_HI     = 48;             // last scored index, 34 terms
    localparam int WS_DIV   = 8;              // clk cycles per sample period

    typedef logic signed [5:0]             lag_t;
    typedef logic        [5:0]             score_t;    // max count 34
    typedef logic        [5:0]             sidx_t;
    typedef logic        [1:0]             mic_sel_t;
    typedef logic [$clog2(PAIR_NUM)-1:0]   pair_idx_t;
    typedef logic [$clog2(WS_DIV)-1:0]     ph_t;       // word select phase

    // mic pair table, walked in this order by the controller
    localparam mic_sel_t PAIR_A [PAIR_NUM] = '{2'd0, 2'd0, 2'd0, 2'd1, 2'd1, 2'd2};
    localparam mic_sel_t PAIR_B [PAIR_NUM] = '{2'd1, 2'd2, 2'd3, 2'd2, 2'd3, 2'd3};

    //////////////////////////////
    // apb register map
    //////////////////////////////
    localparam logic [7:0] ADDR_CTRL   = 8'h00;
    localparam logic [7:0] ADDR_STATUS = 8'h04;
    localparam logic [7:0] ADDR_LAG0   = 8'h08;   // lag0..lag5 every 4 bytes

    localparam int CTRL_START_BIT  = 0;       // write one to start
    localparam int CTRL_IRQ_EN_BIT = 1;
    localparam int STAT_BUSY_BIT   = 0;
    localparam int STAT_DONE_BIT   = 1;       // sticky, write one clears

endpackage

`default_nettype wire
